// File: Makefile
# Verilator flow for the ALU execute unit

LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module alu_exec_unit

sim:
	verilator --binary --timing --assert -j 0 -f build.f \
		--top-module alu_exec_unit_tb -Mdir obj_dir
	./obj_dir/Valu_exec_unit_tb | tee $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@if ! grep -q "=== PASS ===" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: build.f
hw/alu_pkg.sv
hw/alu_issue_queue.sv
hw/alu_core.sv
hw/alu_exec_stage.sv
hw/alu_result_queue.sv
hw/alu_exec_unit.sv
dv/alu_exec_unit_tb.sv

// File: dv/alu_exec_unit_tb.sv
`timescale 1ns/10ps
/*
 * ALU execute unit testbench
 * Table of ops with expected result, flags and error, sent against input
 * credits, results checked in order, sink credits returned fast or late
 */

module alu_exec_unit_tb;

  import alu_pkg::*;

  localparam int IN_DEPTH    = 4;
  localparam int RES_DEPTH   = 4;
  localparam int OUT_CREDITS = 2;
  localparam int N_ROWS      = 27;
  localparam int NUM_PASSES  = 2;  // Fast credits then late credits

  logic        clk;
  logic        rst_n;
  logic        op_valid;
  alu_op_e     op_code;
  logic [15:0] op_a;
  logic [15:0] op_b;
  logic        out_credit;
  logic        in_credit;
  logic        res_valid;
  logic [15:0] res_data;
  logic [2:0]  res_flags;
  logic        res_err;

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  logic [3:0]  tbl_op   [N_ROWS];
  logic [15:0] tbl_a    [N_ROWS];
  logic [15:0] tbl_b    [N_ROWS];
  logic [15:0] tbl_res  [N_ROWS];
  logic [2:0]  tbl_flag [N_ROWS];  // {Z, V, N}
  logic        tbl_err  [N_ROWS];
  int          n_added = 0;

  int err_cnt   = 0;
  int ops_sent  = 0;  // Ops pushed by the source
  int cred_back = 0;  // in_credit pulses seen
  int rx_cnt    = 0;  // Results taken by the sink
  int ret_cnt   = 0;  // out_credit pulses driven
  int cyc       = 0;
  int seed      = 32'h3239;
  bit slow_mode = 1'b0;
  int due_q [$];      // Cycle at which each sink credit goes back

  alu_exec_unit #(
    .IN_DEPTH    (IN_DEPTH),
    .RES_DEPTH   (RES_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_alu_exec_unit (
    .clk        (clk),
    .rst_n      (rst_n),
    .op_valid   (op_valid),
    .op_code    (op_code),
    .op_a       (op_a),
    .op_b       (op_b),
    .out_credit (out_credit),
    .in_credit  (in_credit),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_flags  (res_flags),
    .res_err    (res_err)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk) cyc <= cyc + 1;

  // Watchdog budget per pass scales with table length
  initial begin
    repeat (NUM_PASSES * (N_ROWS * 40 + 200)) @(posedge clk);
    $display("Timeout: results did not arrive, %0d of %0d rows seen", rx_cnt, N_ROWS);
    $display("=== FAIL ===");
    $finish;
  end

  task automatic add_row(input logic [3:0] op, input logic [15:0] a, input logic [15:0] b,
                         input logic [15:0] res, input logic [2:0] flags, input logic err);
    tbl_op[n_added]   = op;
    tbl_a[n_added]    = a;
    tbl_b[n_added]    = b;
    tbl_res[n_added]  = res;
    tbl_flag[n_added] = flags;
    tbl_err[n_added]  = err;
    n_added++;
  endtask

  task automatic apply_reset();
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
  endtask

  task automatic check_result(input int idx);
    if (res_data !== tbl_res[idx]) begin
      err_cnt++;
      $display("Fail res_data row %0d: expected %h, got %h", idx, tbl_res[idx], res_data);
    end
    if (res_flags !== tbl_flag[idx]) begin
      err_cnt++;
      $display("Fail res_flags row %0d: expected %h, got %h", idx, tbl_flag[idx], res_flags);
    end
    if (res_err !== tbl_err[idx]) begin
      err_cnt++;
      $display("Fail res_err row %0d: expected %h, got %h", idx, tbl_err[idx], res_err);
    end
  endtask

  //////////////////////////////
  // Source, sink, credit return
  //////////////////////////////
  task automatic run_source();
    int i;
    i = 0;
    while (i < N_ROWS) begin
      @(posedge clk);
      #1;
      if (ops_sent < IN_DEPTH + cred_back) begin  // Holds a credit
        op_valid = 1'b1;
        op_code  = alu_op_e'(tbl_op[i]);
        op_a     = tbl_a[i];
        op_b     = tbl_b[i];
        ops_sent++;
        i++;
      end else begin
        op_valid = 1'b0;
      end
    end
    @(posedge clk);
    #1 op_valid = 1'b0;
  endtask

  task automatic run_sink();
    int delay;
    while (rx_cnt < N_ROWS) begin
      @(negedge clk);  // Outputs settled mid-cycle
      if (in_credit)
        cred_back++;
      if (res_valid) begin
        check_result(rx_cnt);
        rx_cnt++;
        if (rx_cnt > ret_cnt + OUT_CREDITS) begin
          err_cnt++;
          $display("Result %0d sent with no output credit left", rx_cnt - 1);
        end
        delay = slow_mode ? int'($unsigned($random(seed)) % 6) : 0;
        due_q.push_back(cyc + delay);
      end
      if (ops_sent - rx_cnt > IN_DEPTH + RES_DEPTH + 1) begin
        err_cnt++;
        $display("Too many operations in flight: %0d", ops_sent - rx_cnt);
      end
    end
  endtask

  task automatic run_credits();
    while (rx_cnt < N_ROWS || due_q.size() > 0) begin
      @(posedge clk);
      #1;
      if (due_q.size() > 0 && due_q[0] <= cyc) begin
        void'(due_q.pop_front());
        out_credit = 1'b1;  // One credit per cycle at most
        ret_cnt++;
      end else begin
        out_credit = 1'b0;
      end
    end
    @(posedge clk);
    #1 out_credit = 1'b0;
  endtask

  initial begin
    alu_word_u pw;
    rst_n      = 1'b0;
    op_valid   = 1'b0;
    op_code    = ADD;
    op_a       = '0;
    op_b       = '0;
    out_credit = 1'b0;

    // PADDSB expected lanes 7, -8, 5, 7 from 7835 + 1F24
    pw.nib[3] = 4'sd7;   // 7 + 1 clamps high
    pw.nib[2] = 4'h8;    // -8 + -1 clamps low
    pw.nib[1] = 4'sd5;
    pw.nib[0] = 4'sd7;   // 5 + 4 clamps high

    // Flags carried row to row as {Z, V, N}
    add_row(ADD,    16'h0001, 16'h0002, 16'h0003, 3'b000, 1'b0);
    add_row(ADD,    16'h7000, 16'h2000, 16'h7FFF, 3'b010, 1'b0);  // Positive overflow
    add_row(ADD,    16'h8000, 16'hFFFF, 16'h8000, 3'b011, 1'b0);  // Negative overflow
    add_row(SUB,    16'h0005, 16'h0005, 16'h0000, 3'b100, 1'b0);
    add_row(SUB,    16'h8000, 16'h0001, 16'h8000, 3'b011, 1'b0);
    add_row(SUB,    16'h7FFF, 16'hFFFF, 16'h7FFF, 3'b010, 1'b0);
    add_row(ADD,    16'hFFFE, 16'h0001, 16'hFFFF, 3'b001, 1'b0);  // N set
    add_row(LLB,    16'h1234, 16'hABCD, 16'h12CD, 3'b001, 1'b0);  // Flags held
    add_row(LHB,    16'h1234, 16'h00EF, 16'hEF34, 3'b001, 1'b0);
    add_row(XOR,    16'h5A5A, 16'h5A5A, 16'h0000, 3'b101, 1'b0);  // Only Z moves
    add_row(XOR,    16'hF0F0, 16'h0FF0, 16'hFF00, 3'b001, 1'b0);
    add_row(LW,     16'h1235, 16'h0010, 16'h1254, 3'b001, 1'b0);
    add_row(SW,     16'h7001, 16'h1000, 16'h9000, 3'b001, 1'b0);  // No clamp on address
    add_row(RED,    16'h7F01, 16'h7F02, 16'h0101, 3'b001, 1'b0);
    add_row(RED,    16'h80FF, 16'h8001, 16'hFF00, 3'b001, 1'b0);
    add_row(SLL,    16'h0001, 16'hFFF4, 16'h0010, 3'b001, 1'b0);  // Only b[3:0] counts
    add_row(SRA,    16'h8000, 16'h0003, 16'hF000, 3'b001, 1'b0);
    add_row(ROR,    16'h1234, 16'h0004, 16'h4123, 3'b001, 1'b0);
    add_row(SLL,    16'h8000, 16'h0001, 16'h0000, 3'b101, 1'b0);
    add_row(PADDSB, 16'h7835, 16'h1F24, pw.val,   3'b101, 1'b0);
    add_row(4'hC,   16'hFFFF, 16'hFFFF, 16'h0000, 3'b101, 1'b1);  // Invalid
    add_row(ADD,    16'h0000, 16'h0000, 16'h0000, 3'b100, 1'b0);
    add_row(4'hD,   16'h1234, 16'h5678, 16'h0000, 3'b100, 1'b1);
    add_row(4'hE,   16'h8000, 16'h8000, 16'h0000, 3'b100, 1'b1);
    add_row(SUB,    16'h0003, 16'h0005, 16'hFFFE, 3'b001, 1'b0);
    add_row(PADDSB, 16'h1111, 16'h2222, 16'h3333, 3'b001, 1'b0);
    add_row(4'hF,   16'h0001, 16'h0001, 16'h0000, 3'b001, 1'b1);

    for (int p = 0; p < NUM_PASSES; p++) begin
      slow_mode = (p == 1);
      ops_sent  = 0;
      cred_back = 0;
      rx_cnt    = 0;
      ret_cnt   = 0;
      due_q.delete();
      apply_reset();  // Flags restart from zero each pass
      fork
        run_source();
        run_sink();
        run_credits();
      join
      repeat (4) @(posedge clk);
      #1;
      if (cred_back != ops_sent) begin
        err_cnt++;
        $display("Fail in_credit count: expected %h, got %h", ops_sent, cred_back);
      end
    end

    $display("Errors: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: hw/alu_core.sv
`timescale 1ns/10ps
/*
 * ALU core
 * Combinational 16-bit ALU, result plus overflow and invalid-opcode error
 */

module alu_core (
  input  alu_pkg::alu_op_e           code,
  input  logic [alu_pkg::DATA_W-1:0] a,
  input  logic [alu_pkg::DATA_W-1:0] b,
  output logic [alu_pkg::DATA_W-1:0] result,
  output logic                       ovf,  // ADD/SUB saturated
  output logic                       err   // Opcode C to F
);

  import alu_pkg::*;

  //////////////////////////////
  // Adder path
  //////////////////////////////
  logic              is_mem;   // LW or SW address calculation
  logic              is_sub;
  logic              is_arith; // ADD or SUB, saturating
  logic [DATA_W-1:0] add_a;
  logic [DATA_W-1:0] add_b;
  logic [DATA_W-1:0] sum_raw;
  logic [DATA_W-1:0] sum_sat;
  logic              pos_ov;
  logic              neg_ov;

  assign is_mem   = (code == LW) || (code == SW);
  assign is_sub   = (code == SUB);
  assign is_arith = (code == ADD) || is_sub;

  // Address form: base word aligned, offset scaled by two
  assign add_a = is_mem ? {a[DATA_W-1:1], 1'b0} : a;
  assign add_b = is_mem ? {b[DATA_W-2:0], 1'b0} : b;

  assign sum_raw = is_sub ? (add_a - add_b) : (add_a + add_b);

  // Sign of operands versus sign of result
  assign pos_ov = is_sub ? (~add_a[DATA_W-1] &  add_b[DATA_W-1] &  sum_raw[DATA_W-1])
                         : (~add_a[DATA_W-1] & ~add_b[DATA_W-1] &  sum_raw[DATA_W-1]);
  assign neg_ov = is_sub ? ( add_a[DATA_W-1] & ~add_b[DATA_W-1] & ~sum_raw[DATA_W-1])
                         : ( add_a[DATA_W-1] &  add_b[DATA_W-1] & ~sum_raw[DATA_W-1]);

  // Clamp to the signed range, only ADD/SUB saturate
  always_comb begin
    if (is_arith && pos_ov)
      sum_sat = 16'h7FFF;
    else if (is_arith && neg_ov)
      sum_sat = 16'h8000;
    else
      sum_sat = sum_raw;
  end

  assign ovf = is_arith && (pos_ov || neg_ov);

  //////////////////////////////
  // Byte reduction
  //////////////////////////////
  logic [8:0]  red_hi;   // Signed high byte sum
  logic [8:0]  red_lo;   // Signed low byte sum
  logic [9:0]  red_sum;

  assign red_hi  = {a[15], a[15:8]} + {b[15], b[15:8]};
  assign red_lo  = {a[7], a[7:0]} + {b[7], b[7:0]};
  assign red_sum = {red_hi[8], red_hi} + {red_lo[8], red_lo};

  // Shifts by the low four bits of b
  logic [3:0]          shamt;
  logic [2*DATA_W-1:0] ror_wide;  // Doubled word, low half is the rotate

  assign shamt    = b[3:0];
  assign ror_wide = {a, a} >> shamt;

  //////////////////////////////
  // Parallel nibble add
  //////////////////////////////
  alu_word_u         pa;
  alu_word_u         pb;
  alu_word_u         pr;
  logic signed [4:0] lane_sum [NIB_N];

  assign pa = a;
  assign pb = b;

  always_comb begin
    for (int i = 0; i < NIB_N; i++) begin
      lane_sum[i] = {pa.nib[i][3], pa.nib[i]} + {pb.nib[i][3], pb.nib[i]};
      case (lane_sum[i][4:3])
        2'b01:   pr.nib[i] = 4'sd7;       // Positive overflow
        2'b10:   pr.nib[i] = 4'b1000;     // Negative overflow, -8
        default: pr.nib[i] = lane_sum[i][3:0];
      endcase
    end
  end

  // Result select
  always_comb begin
    result = '0;
    err    = 1'b0;
    case (code)
      ADD, SUB, LW, SW: result = sum_sat;
      XOR:              result = a ^ b;
      RED:              result = {{(DATA_W-10){red_sum[9]}}, red_sum};
      SLL:              result = a << shamt;
      SRA:              result = $signed(a) >>> shamt;
      ROR:              result = ror_wide[DATA_W-1:0];
      PADDSB:           result = pr.val;
      LLB:              result = {a[15:8], b[7:0]};  // Keep high byte
      LHB:              result = {b[7:0], a[7:0]};   // Keep low byte
      default: begin
        result = '0;  // Invalid opcode
        err    = 1'b1;
      end
    endcase
  end

endmodule

// File: hw/alu_exec_stage.sv
`timescale 1ns/10ps
/*
 * ALU execute stage
 * One register stage around the ALU core, owns the Z/V/N flag register
 */

module alu_exec_stage (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       iss_valid,
  input  alu_pkg::alu_op_e           iss_code,
  input  logic [alu_pkg::DATA_W-1:0] iss_a,
  input  logic [alu_pkg::DATA_W-1:0] iss_b,
  output logic                       ex_valid,
  output logic [alu_pkg::DATA_W-1:0] ex_data,
  output logic [2:0]                 ex_flags,  // Flag register after this op
  output logic                       ex_err
);

  import alu_pkg::*;

  logic [DATA_W-1:0] core_result;
  logic              core_ovf;
  logic              core_err;
  logic [2:0]        flags_nxt;

  alu_core i_alu_core (
    .code   (iss_code),
    .a      (iss_a),
    .b      (iss_b),
    .result (core_result),
    .ovf    (core_ovf),
    .err    (core_err)
  );

  //////////////////////////////
  // Flag rules
  //////////////////////////////
  always_comb begin
    flags_nxt = ex_flags;  // Hold by default
    if (iss_valid) begin
      case (iss_code)
        ADD, SUB: begin
          flags_nxt[FLAG_Z] = (core_result == '0);
          flags_nxt[FLAG_V] = core_ovf;
          flags_nxt[FLAG_N] = core_result[DATA_W-1];
        end
        XOR, SLL, SRA, ROR: flags_nxt[FLAG_Z] = (core_result == '0);  // Z only
        default: ;  // Others and invalid opcodes keep flags
      endcase
    end
  end

  // Control and flags
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_flags <= '0;
    end else begin
      ex_valid <= iss_valid;
      ex_flags <= flags_nxt;
    end
  end

  // Payload, loaded only on a popped op
  always_ff @(posedge clk) begin
    if (iss_valid) begin
      ex_data <= core_result;
      ex_err  <= core_err;
    end
  end

  // Invalid opcode must reach the result side as zero
  a_err_zero_data: assert property (
    @(posedge clk) disable iff (!rst_n) (ex_valid && ex_err) |-> (ex_data == '0)
  );

endmodule

// File: hw/alu_exec_unit.sv
`timescale 1ns/10ps
/*
 * ALU execute unit top
 * Issue queue, execute stage and result queue, credit flow on both sides
 */

module alu_exec_unit #(
  parameter int IN_DEPTH    = 4,
  parameter int RES_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       op_valid,
  input  alu_pkg::alu_op_e           op_code,
  input  logic [alu_pkg::DATA_W-1:0] op_a,
  input  logic [alu_pkg::DATA_W-1:0] op_b,
  input  logic                       out_credit,
  output logic                       in_credit,
  output logic                       res_valid,
  output logic [alu_pkg::DATA_W-1:0] res_data,
  output logic [2:0]                 res_flags,
  output logic                       res_err
);

  import alu_pkg::*;

  //////////////////////////////
  // Internal links
  //////////////////////////////
  logic              res_space;  // Result side reservation
  logic              iss_valid;  // Issue to exec
  alu_op_e           iss_code;
  logic [DATA_W-1:0] iss_a;
  logic [DATA_W-1:0] iss_b;
  logic              ex_valid;   // Exec to result side
  logic [DATA_W-1:0] ex_data;
  logic [2:0]        ex_flags;
  logic              ex_err;

  alu_issue_queue #(
    .IN_DEPTH (IN_DEPTH)
  ) i_alu_issue_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .op_valid  (op_valid),
    .op_code   (op_code),
    .op_a      (op_a),
    .op_b      (op_b),
    .res_space (res_space),
    .in_credit (in_credit),
    .iss_valid (iss_valid),
    .iss_code  (iss_code),
    .iss_a     (iss_a),
    .iss_b     (iss_b)
  );

  alu_exec_stage i_alu_exec_stage (
    .clk       (clk),
    .rst_n     (rst_n),
    .iss_valid (iss_valid),
    .iss_code  (iss_code),
    .iss_a     (iss_a),
    .iss_b     (iss_b),
    .ex_valid  (ex_valid),
    .ex_data   (ex_data),
    .ex_flags  (ex_flags),
    .ex_err    (ex_err)
  );

  alu_result_queue #(
    .RES_DEPTH   (RES_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) i_alu_result_queue (
    .clk        (clk),
    .rst_n      (rst_n),
    .ex_valid   (ex_valid),
    .ex_data    (ex_data),
    .ex_flags   (ex_flags),
    .ex_err     (ex_err),
    .out_credit (out_credit),
    .res_space  (res_space),
    .res_valid  (res_valid),
    .res_data   (res_data),
    .res_flags  (res_flags),
    .res_err    (res_err)
  );

endmodule

// File: hw/alu_issue_queue.sv
`timescale 1ns/10ps
/*
 * ALU issue queue
 * Circular FIFO fed by a credit-based source, pops one entry per cycle
 * while the result side has room and hands one credit back per pop
 */

module alu_issue_queue #(
  parameter int IN_DEPTH = 4
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       op_valid,   // Push, source holds a credit
  input  alu_pkg::alu_op_e           op_code,
  input  logic [alu_pkg::DATA_W-1:0] op_a,
  input  logic [alu_pkg::DATA_W-1:0] op_b,
  input  logic                       res_space,  // Result side can take one more
  output logic                       in_credit,  // One credit back to the source
  output logic                       iss_valid,  // Entry popped this cycle
  output alu_pkg::alu_op_e           iss_code,
  output logic [alu_pkg::DATA_W-1:0] iss_a,
  output logic [alu_pkg::DATA_W-1:0] iss_b
);

  import alu_pkg::*;

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_W = $clog2(IN_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(IN_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(IN_DEPTH);

  // Entry storage
  alu_op_e           code_mem [IN_DEPTH];
  logic [DATA_W-1:0] a_mem    [IN_DEPTH];
  logic [DATA_W-1:0] b_mem    [IN_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // Occupancy

  // Pop whenever something is held and downstream has reserved room
  assign iss_valid = (count != '0) && res_space;
  assign iss_code  = code_mem[rd_ptr];
  assign iss_a     = a_mem[rd_ptr];
  assign iss_b     = b_mem[rd_ptr];

  //////////////////////////////
  // Storage write
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (op_valid) begin
      code_mem[wr_ptr] <= op_code;
      a_mem[wr_ptr]    <= op_a;
      b_mem[wr_ptr]    <= op_b;
    end
  end

  // Pointers, count and credit pulse
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      count     <= '0;
      in_credit <= 1'b0;
    end else begin
      in_credit <= iss_valid;  // Credit goes back the cycle after the pop
      if (op_valid)
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (iss_valid)
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({op_valid, iss_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Idle, or push and pop together
      endcase
    end
  end

  // Source must never push without a credit
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) op_valid |-> (count != FULL_CNT)
  );

endmodule

// File: hw/alu_pkg.sv
/*
 * ALU execute unit shared definitions
 * Opcode encoding, dual-view data word and Z/V/N flag layout
 */

package alu_pkg;

  //////////////////////////////
  // Datapath sizes
  //////////////////////////////
  localparam int DATA_W = 16;          // Operand and result width
  localparam int NIB_N  = DATA_W / 4;  // Nibble lanes for PADDSB

  // Opcodes 0x0 to 0xB, 0xC to 0xF are invalid
  typedef enum logic [3:0] {
    ADD    = 4'h0,  // Saturating add
    SUB    = 4'h1,  // Saturating subtract
    XOR    = 4'h2,
    RED    = 4'h3,  // Byte reduction add
    SLL    = 4'h4,
    SRA    = 4'h5,
    ROR    = 4'h6,
    PADDSB = 4'h7,  // Parallel nibble add with saturation
    LW     = 4'h8,  // Load address
    SW     = 4'h9,  // Store address
    LLB    = 4'hA,  // Load low byte
    LHB    = 4'hB   // Load high byte
  } alu_op_e;

  // One signed nibble
  typedef logic signed [3:0] nib_t;

  // Same word seen as one signed value or as four signed nibbles
  typedef union packed {
    logic signed [DATA_W-1:0] val;
    nib_t [NIB_N-1:0]         nib;  // nib[0] is bits 3:0
  } alu_word_u;

  //////////////////////////////
  // Flag word bit positions
  //////////////////////////////
  localparam int FLAG_Z = 2;  // Result zero
  localparam int FLAG_V = 1;  // Signed overflow
  localparam int FLAG_N = 0;  // Result negative

endpackage

// File: hw/alu_result_queue.sv
`timescale 1ns/10ps
/*
 * ALU result queue
 * FIFO of finished results, sent downstream one per cycle against credits,
 * reports room upstream with one slot reserved for the exec register
 */

module alu_result_queue #(
  parameter int RES_DEPTH   = 4,
  parameter int OUT_CREDITS = 2
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       ex_valid,
  input  logic [alu_pkg::DATA_W-1:0] ex_data,
  input  logic [2:0]                 ex_flags,
  input  logic                       ex_err,
  input  logic                       out_credit,  // Sink returns one credit
  output logic                       res_space,
  output logic                       res_valid,
  output logic [alu_pkg::DATA_W-1:0] res_data,
  output logic [2:0]                 res_flags,
  output logic                       res_err
);

  import alu_pkg::*;

  localparam int PTR_W = (RES_DEPTH > 1) ? $clog2(RES_DEPTH) : 1;
  localparam int CNT_W = $clog2(RES_DEPTH + 1);
  localparam int CR_W  = $clog2(OUT_CREDITS + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(RES_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(RES_DEPTH);
  localparam logic [CR_W-1:0]  MAX_CR   = CR_W'(OUT_CREDITS);

  logic [DATA_W-1:0] data_mem [RES_DEPTH];
  logic [2:0]        flag_mem [RES_DEPTH];
  logic              err_mem  [RES_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic [CNT_W-1:0] free_cnt;
  logic [CR_W-1:0]  credits;  // Downstream credits held

  // Send while holding a result and a credit
  assign res_valid = (count != '0) && (credits != '0);
  assign res_data  = data_mem[rd_ptr];
  assign res_flags = flag_mem[rd_ptr];
  assign res_err   = err_mem[rd_ptr];

  // Keep one slot for whatever sits in the exec register
  assign free_cnt  = FULL_CNT - count;
  assign res_space = free_cnt > CNT_W'(ex_valid);

  always_ff @(posedge clk) begin
    if (ex_valid) begin
      data_mem[wr_ptr] <= ex_data;
      flag_mem[wr_ptr] <= ex_flags;
      err_mem[wr_ptr]  <= ex_err;
    end
  end

  //////////////////////////////
  // Pointers, count, credits
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      credits <= MAX_CR;  // Sink starts with all slots free
    end else begin
      if (ex_valid)  wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (res_valid) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
      case ({ex_valid, res_valid})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
      case ({res_valid, out_credit})
        2'b10:   credits <= credits - 1'b1;  // Spent on a send
        2'b01:   credits <= credits + 1'b1;  // Returned by sink
        default: credits <= credits;         // Send and return cancel
      endcase
    end
  end

  // Space reservation upstream keeps the queue from overflowing
  a_no_write_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) ex_valid |-> (count != FULL_CNT)
  );

  // Sink must not return more credits than it was given
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n) credits <= MAX_CR
  );

endmodule
